// ==== compile.f ====
chip8_pkg.sv
chip8_memory.sv
chip8_mem_arbiter.sv
chip8_host_port.sv
chip8_core.sv
chip8_top.sv
tb_chip8_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timescale 1ns/1ps --top-module tb_chip8_top -f compile.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_chip8_top 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb_chip8_top.sv ====
// Directed testbench for chip8_top
// Host bus tasks, program loader, reference model and timeout
module tb_chip8_top;
    timeunit 1ns;
    timeprecision 100ps;
    import chip8_pkg::*;

    localparam int CLK_HALF       = 4;
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int RESP_WAIT      = 4;
    localparam logic [31:0] SEED  = 32'h85446433;

    localparam logic [HOST_ADDR_W-1:0] UNMAPPED_ADDR = 18'h20;
    localparam logic [HOST_DATA_W-1:0] BAD_READ      = 32'd101;
    // State codes for writes and the code read back when paused
    localparam logic [HOST_DATA_W-1:0] WR_RUN    = 32'd0;
    localparam logic [HOST_DATA_W-1:0] WR_STEP   = 32'd1;
    localparam logic [HOST_DATA_W-1:0] WR_PAUSE  = 32'd3;
    localparam logic [HOST_DATA_W-1:0] RD_PAUSED = 32'd2;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   chipselect;
    logic                   write;
    logic [HOST_ADDR_W-1:0] address;
    logic [HOST_DATA_W-1:0] writedata;
    logic [HOST_DATA_W-1:0] data_out;
    logic                   data_valid;

    logic [31:0]           rng_state;
    int                    cycle_count = 0;
    // Expected core state across all tests
    logic [BYTE_W-1:0]     exp_v [NUM_VREGS];
    logic [MEM_ADDR_W-1:0] exp_i;
    logic [MEM_ADDR_W-1:0] exp_pc;
    logic [INSTR_W-1:0]    prog [16];

    chip8_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

    always #CLK_HALF clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            abort_run($sformatf("[ERROR] %0d ns: %s got 0x%0h, expected 0x%0h",
                                $time, what, got, expected));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // One access with a one-cycle chipselect and a wait for data_valid
    task automatic bus_access(input logic wr, input logic [HOST_ADDR_W-1:0] addr,
                              input logic [HOST_DATA_W-1:0] wdata,
                              output logic [HOST_DATA_W-1:0] rdata);
        int waited;
        chipselect = 1'b1;
        write      = wr;
        address    = addr;
        writedata  = wdata;
        @(posedge clk);
        #1;
        chipselect = 1'b0;
        write      = 1'b0;
        // Response is due two cycles after the access cycle
        check_equal({31'd0, data_valid}, 32'd0, "data_valid one cycle after access");
        waited     = 0;
        while (!data_valid && waited < RESP_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!data_valid) begin
            abort_run("Host access got no data_valid within 4 cycles");
        end
        check_equal(waited, 32'd1, "Cycles waited for data_valid");
        rdata = data_out;
    endtask

    task automatic reg_write(input logic [HOST_ADDR_W-1:0] addr,
                             input logic [HOST_DATA_W-1:0] data);
        logic [HOST_DATA_W-1:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic reg_read(input logic [HOST_ADDR_W-1:0] addr,
                            output logic [HOST_DATA_W-1:0] data);
        bus_access(1'b0, addr, 32'd0, data);
    endtask

    task automatic mem_write_byte(input logic [MEM_ADDR_W-1:0] a, input logic [BYTE_W-1:0] d);
        reg_write(HOST_MEM, {11'd0, 1'b1, a, d});
    endtask

    // Address is latched by a write without bit 20, then read back
    task automatic mem_read_byte(input logic [MEM_ADDR_W-1:0] a,
                                 output logic [HOST_DATA_W-1:0] data);
        reg_write(HOST_MEM, {11'd0, 1'b0, a, 8'h00});
        reg_read(HOST_MEM, data);
    endtask

    task automatic check_vregs();
        logic [HOST_DATA_W-1:0] rd;
        for (int r = 0; r < NUM_VREGS; r++) begin
            reg_read(HOST_VREG_BASE + {14'd0, r[3:0]}, rd);
            check_equal(rd, {24'd0, exp_v[r[3:0]]}, $sformatf("V%0d", r));
        end
    endtask

    // Steps the instruction rules over prog until a jump to itself
    task automatic run_model();
        logic [MEM_ADDR_W-1:0] pc;
        logic [INSTR_W-1:0]    op;
        logic                  done;
        int                    steps;
        pc    = RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 64) begin
            op = prog[4'((pc - RESET_PC) >> 1)];
            case (op[15:12])
                4'h1: begin
                    done = (op[11:0] == pc);
                    pc   = op[11:0];
                end
                4'h3: pc = (exp_v[op[11:8]] == op[7:0]) ? pc + 12'd4 : pc + 12'd2;
                4'h6: begin
                    exp_v[op[11:8]] = op[7:0];
                    pc = pc + 12'd2;
                end
                4'h7: begin
                    exp_v[op[11:8]] = exp_v[op[11:8]] + op[7:0];
                    pc = pc + 12'd2;
                end
                4'hA: begin
                    exp_i = op[11:0];
                    pc    = pc + 12'd2;
                end
                default: pc = pc + 12'd2;
            endcase
            steps++;
        end
        exp_pc = pc;
    endtask

    task automatic reset_values_test();
        logic [HOST_DATA_W-1:0] rd;
        reg_read(HOST_PC, rd);
        check_equal(rd, 32'h200, "PC after reset");
        reg_read(HOST_STATE, rd);
        check_equal(rd, RD_PAUSED, "State after reset");
        reg_read(HOST_I, rd);
        check_equal(rd, 32'd0, "I after reset");
        check_vregs();
    endtask

    task automatic host_access_test();
        logic [HOST_DATA_W-1:0] rd;
        logic [MEM_ADDR_W-1:0]  a;
        logic [BYTE_W-1:0]      d;
        for (int r = 0; r < NUM_VREGS; r++) begin
            exp_v[r[3:0]] = BYTE_W'(next_random());
            reg_write(HOST_VREG_BASE + {14'd0, r[3:0]}, {24'd0, exp_v[r[3:0]]});
        end
        check_vregs();
        exp_i = MEM_ADDR_W'(next_random());
        reg_write(HOST_I, {20'd0, exp_i});
        reg_read(HOST_I, rd);
        check_equal(rd, {20'd0, exp_i}, "I readback");
        for (int k = 0; k < 20; k++) begin
            a = MEM_ADDR_W'(next_random());
            // Keep clear of the program page
            if (a[11:8] == 4'h2) begin
                a = a ^ 12'h400;
            end
            d = BYTE_W'(next_random());
            mem_write_byte(a, d);
            mem_read_byte(a, rd);
            check_equal(rd, {12'd0, a, d}, $sformatf("Memory byte at 0x%0h", a));
        end
        reg_read(UNMAPPED_ADDR, rd);
        check_equal(rd, BAD_READ, "Unmapped read");
    endtask

    task automatic single_step_test();
        logic [HOST_DATA_W-1:0] rd;
        logic [3:0]             x;
        logic [BYTE_W-1:0]      nn;
        int                     polls;
        x  = 4'(next_random());
        nn = BYTE_W'(next_random());
        reg_write(HOST_PC, 32'h200);
        mem_write_byte(12'h200, {4'h6, x});
        mem_write_byte(12'h201, nn);
        reg_write(HOST_STATE, WR_STEP);
        polls = 0;
        rd    = WR_STEP;
        while (rd != RD_PAUSED && polls < 20) begin
            reg_read(HOST_STATE, rd);
            polls++;
        end
        if (rd != RD_PAUSED) begin
            abort_run("Single step never returned the core to the paused state");
        end
        exp_v[x] = nn;
        reg_read(HOST_VREG_BASE + {14'd0, x}, rd);
        check_equal(rd, {24'd0, nn}, "VX after step");
        reg_read(HOST_PC, rd);
        check_equal(rd, 32'h202, "PC after step");
    endtask

    task automatic program_run_test();
        logic [HOST_DATA_W-1:0] rd;
        logic [MEM_ADDR_W-1:0]  a;
        logic [3:0]             w;
        for (int k = 0; k < 16; k++) begin
            prog[k[3:0]] = 16'h0000;
        end
        prog[0] = 16'hA3A5;
        prog[1] = 16'h6190;
        // 0x90 + 0x50 + 0x40 + 0x35 wraps to 0x55
        prog[2] = 16'h7150;
        prog[3] = 16'h7140;
        prog[4] = 16'h7135;
        prog[5] = 16'h3155;
        prog[6] = 16'h62EE;
        prog[7] = 16'h3100;
        prog[8] = 16'h6377;
        prog[9] = 16'h1212;
        for (int k = 0; k < 10; k++) begin
            mem_write_byte(RESET_PC + 12'(2 * k), prog[k[3:0]][15:8]);
            mem_write_byte(RESET_PC + 12'(2 * k + 1), prog[k[3:0]][7:0]);
        end
        reg_write(HOST_PC, 32'h200);
        run_model();
        reg_write(HOST_STATE, WR_RUN);
        // 75 read pairs of 4 cycles each give about 300 cycles of contention
        for (int k = 0; k < 75; k++) begin
            a = RESET_PC + 12'(k % 20);
            w = 4'((k % 20) / 2);
            mem_read_byte(a, rd);
            check_equal(rd, {12'd0, a, (a[0] ? prog[w][7:0] : prog[w][15:8])},
                        "Program byte during run");
        end
        reg_write(HOST_STATE, WR_PAUSE);
        wait_cycles(8);
        check_vregs();
        reg_read(HOST_I, rd);
        check_equal(rd, {20'd0, exp_i}, "I after program");
        reg_read(HOST_PC, rd);
        check_equal(rd, {20'd0, exp_pc}, "PC after program");
    endtask

    task automatic pause_hold_test();
        logic [HOST_DATA_W-1:0] rd;
        // A load into V0 at 0x300 would move PC and change V0 if executed
        mem_write_byte(12'h300, 8'h60);
        mem_write_byte(12'h301, ~exp_v[0]);
        reg_write(HOST_PC, 32'h300);
        wait_cycles(50);
        reg_read(HOST_PC, rd);
        check_equal(rd, 32'h300, "PC while paused");
        check_vregs();
        // Jump to self at 0x300
        mem_write_byte(12'h300, 8'h13);
        mem_write_byte(12'h301, 8'h00);
        reg_write(HOST_STATE, WR_RUN);
        repeat (10) begin
            wait_cycles(4);
            reg_read(HOST_PC, rd);
            check_equal(rd, 32'h300, "PC on jump to self");
        end
        reg_write(HOST_STATE, WR_PAUSE);
        wait_cycles(8);
        reg_read(HOST_STATE, rd);
        check_equal(rd, RD_PAUSED, "State after final pause");
        check_vregs();
    endtask

    initial begin
        reset      = 1'b1;
        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        rng_state  = SEED;
        exp_i      = '0;
        for (int r = 0; r < NUM_VREGS; r++) begin
            exp_v[r[3:0]] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_values_test();
        host_access_test();
        single_step_test();
        program_run_test();
        pause_hold_test();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== chip8_top.sv ====
// Top level of the interpreter core
// Host port, core, memory arbiter and program memory
module chip8_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              chipselect,
    input  logic                              write,
    input  logic [chip8_pkg::HOST_ADDR_W-1:0] address,
    input  logic [chip8_pkg::HOST_DATA_W-1:0] writedata,
    output logic [chip8_pkg::HOST_DATA_W-1:0] data_out,
    output logic                              data_valid
);
    import chip8_pkg::*;

    run_state_t             run_state;
    logic                   step_done;

    // Host register access into the core
    logic                   host_reg_we;
    logic [HOST_ADDR_W-1:0] host_reg_addr;
    logic [HOST_DATA_W-1:0] host_reg_wdata;
    logic [HOST_DATA_W-1:0] reg_rdata;

    // Memory requesters
    logic                   host_mem_req;
    logic                   host_mem_we;
    logic [MEM_ADDR_W-1:0]  host_mem_addr;
    logic [BYTE_W-1:0]      host_mem_wdata;
    logic                   host_mem_gnt;
    logic                   core_mem_req;
    logic                   core_mem_we;
    logic [MEM_ADDR_W-1:0]  core_mem_addr;
    logic [BYTE_W-1:0]      core_mem_wdata;
    logic                   core_mem_gnt;

    // Shared memory port
    logic [MEM_ADDR_W-1:0]  mem_addr;
    logic                   mem_we;
    logic [BYTE_W-1:0]      mem_wdata;
    logic [BYTE_W-1:0]      mem_rdata;

    chip8_host_port i_host_port (
        .clk            (clk),
        .reset          (reset),
        .chipselect     (chipselect),
        .write          (write),
        .address        (address),
        .writedata      (writedata),
        .data_out       (data_out),
        .data_valid     (data_valid),
        .run_state      (run_state),
        .step_done      (step_done),
        .host_reg_we    (host_reg_we),
        .host_reg_addr  (host_reg_addr),
        .host_reg_wdata (host_reg_wdata),
        .reg_rdata      (reg_rdata),
        .mem_req        (host_mem_req),
        .mem_we         (host_mem_we),
        .mem_addr       (host_mem_addr),
        .mem_wdata      (host_mem_wdata),
        .mem_gnt        (host_mem_gnt),
        .mem_rdata      (mem_rdata)
    );

    chip8_core i_core (
        .clk            (clk),
        .reset          (reset),
        .run_state      (run_state),
        .step_done      (step_done),
        .host_reg_we    (host_reg_we),
        .host_reg_addr  (host_reg_addr),
        .host_reg_wdata (host_reg_wdata),
        .reg_rdata      (reg_rdata),
        .mem_req        (core_mem_req),
        .mem_we         (core_mem_we),
        .mem_addr       (core_mem_addr),
        .mem_wdata      (core_mem_wdata),
        .mem_gnt        (core_mem_gnt),
        .mem_rdata      (mem_rdata)
    );

    chip8_mem_arbiter i_mem_arbiter (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_mem_req),
        .host_we    (host_mem_we),
        .host_addr  (host_mem_addr),
        .host_wdata (host_mem_wdata),
        .host_gnt   (host_mem_gnt),
        .core_req   (core_mem_req),
        .core_we    (core_mem_we),
        .core_addr  (core_mem_addr),
        .core_wdata (core_mem_wdata),
        .core_gnt   (core_mem_gnt),
        .mem_addr   (mem_addr),
        .mem_we     (mem_we),
        .mem_wdata  (mem_wdata)
    );

    chip8_memory i_memory (
        .clk   (clk),
        .addr  (mem_addr),
        .we    (mem_we),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// ==== chip8_core.sv ====
// Fetch/execute sequencer for the CHIP-8 subset
// V register file, index register and program counter
module chip8_core (
    input  logic                              clk,
    input  logic                              reset,
    input  chip8_pkg::run_state_t             run_state,
    output logic                              step_done,
    input  logic                              host_reg_we,
    input  logic [chip8_pkg::HOST_ADDR_W-1:0] host_reg_addr,
    input  logic [chip8_pkg::HOST_DATA_W-1:0] host_reg_wdata,
    output logic [chip8_pkg::HOST_DATA_W-1:0] reg_rdata,
    output logic                              mem_req,
    output logic                              mem_we,
    output logic [chip8_pkg::MEM_ADDR_W-1:0]  mem_addr,
    output logic [chip8_pkg::BYTE_W-1:0]      mem_wdata,
    input  logic                              mem_gnt,
    input  logic [chip8_pkg::BYTE_W-1:0]      mem_rdata
);
    import chip8_pkg::*;

    core_phase_t            phase;
    logic                   hi_wait;
    logic [BYTE_W-1:0]      instr_hi;
    logic [INSTR_W-1:0]     instr;
    opcode_t                opcode;
    logic [VREG_ADDR_W-1:0] x;
    logic [BYTE_W-1:0]      nn;
    logic [MEM_ADDR_W-1:0]  nnn;

    logic [BYTE_W-1:0]      vregs [NUM_VREGS];
    logic [MEM_ADDR_W-1:0]  i_reg;
    logic [MEM_ADDR_W-1:0]  pc;

    logic                   host_is_vreg;
    logic [VREG_ADDR_W-1:0] host_vreg_sel;
    logic                   host_wr_ok;

    // Low byte is taken straight off the read port in EXECUTE
    assign instr  = {instr_hi, mem_rdata};
    assign opcode = opcode_t'(instr[INSTR_W-1 -: 4]);
    assign x      = instr[11:8];
    assign nn     = instr[7:0];
    assign nnn    = instr[11:0];

    // One request, then a gap while the byte comes back
    assign mem_req   = (phase == FETCH_HI) || (phase == FETCH_LO && !hi_wait);
    assign mem_addr  = (phase == FETCH_LO) ? pc + MEM_ADDR_W'(1) : pc;
    assign mem_we    = 1'b0;
    assign mem_wdata = '0;

    assign step_done = (phase == EXECUTE) && (run_state == STEP);

    assign host_is_vreg  = (host_reg_addr >> VREG_ADDR_W) == (HOST_VREG_BASE >> VREG_ADDR_W);
    assign host_vreg_sel = host_reg_addr[VREG_ADDR_W-1:0];
    // Host writes only land between instructions while paused
    assign host_wr_ok    = host_reg_we && run_state == PAUSED && phase == IDLE;

    always_comb begin
        reg_rdata = '0;
        if (host_reg_addr == HOST_I) begin
            reg_rdata = HOST_DATA_W'(i_reg);
        end else if (host_reg_addr == HOST_PC) begin
            reg_rdata = HOST_DATA_W'(pc);
        end else if (host_is_vreg) begin
            reg_rdata = HOST_DATA_W'(vregs[host_vreg_sel]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase   <= IDLE;
            hi_wait <= 1'b0;
        end else begin
            case (phase)
                IDLE: begin
                    if (run_state == RUNNING || run_state == STEP) begin
                        phase <= FETCH_HI;
                    end
                end
                FETCH_HI: begin
                    if (mem_gnt) begin
                        phase   <= FETCH_LO;
                        hi_wait <= 1'b1;
                    end
                end
                FETCH_LO: begin
                    if (hi_wait) begin
                        hi_wait <= 1'b0;
                    end else if (mem_gnt) begin
                        phase <= EXECUTE;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == FETCH_LO && hi_wait) begin
            instr_hi <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= RESET_PC;
            i_reg <= '0;
            for (int r = 0; r < NUM_VREGS; r++) begin
                vregs[r] <= '0;
            end
        end else if (phase == EXECUTE) begin
            case (opcode)
                OP_JUMP: pc <= nnn;
                OP_SKIP_EQ: pc <= (vregs[x] == nn) ? pc + MEM_ADDR_W'(4) : pc + MEM_ADDR_W'(2);
                OP_LOAD: begin
                    vregs[x] <= nn;
                    pc       <= pc + MEM_ADDR_W'(2);
                end
                OP_ADD: begin
                    vregs[x] <= vregs[x] + nn;
                    pc       <= pc + MEM_ADDR_W'(2);
                end
                OP_SET_I: begin
                    i_reg <= nnn;
                    pc    <= pc + MEM_ADDR_W'(2);
                end
                // Unknown opcodes fall through as no-ops
                default: pc <= pc + MEM_ADDR_W'(2);
            endcase
        end else if (host_wr_ok) begin
            if (host_reg_addr == HOST_I) begin
                i_reg <= host_reg_wdata[MEM_ADDR_W-1:0];
            end else if (host_reg_addr == HOST_PC) begin
                pc <= host_reg_wdata[MEM_ADDR_W-1:0];
            end else if (host_is_vreg) begin
                vregs[host_vreg_sel] <= host_reg_wdata[BYTE_W-1:0];
            end
        end
    end

endmodule

// ==== chip8_host_port.sv ====
// Host bus decoder with run-state register
// Two-stage response pipe with a fixed read latency of 2
module chip8_host_port (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              chipselect,
    input  logic                              write,
    input  logic [chip8_pkg::HOST_ADDR_W-1:0] address,
    input  logic [chip8_pkg::HOST_DATA_W-1:0] writedata,
    output logic [chip8_pkg::HOST_DATA_W-1:0] data_out,
    output logic                              data_valid,
    output chip8_pkg::run_state_t             run_state,
    input  logic                              step_done,
    output logic                              host_reg_we,
    output logic [chip8_pkg::HOST_ADDR_W-1:0] host_reg_addr,
    output logic [chip8_pkg::HOST_DATA_W-1:0] host_reg_wdata,
    input  logic [chip8_pkg::HOST_DATA_W-1:0] reg_rdata,
    output logic                              mem_req,
    output logic                              mem_we,
    output logic [chip8_pkg::MEM_ADDR_W-1:0]  mem_addr,
    output logic [chip8_pkg::BYTE_W-1:0]      mem_wdata,
    input  logic                              mem_gnt,
    input  logic [chip8_pkg::BYTE_W-1:0]      mem_rdata
);
    import chip8_pkg::*;

    // Stage 1, the access as seen on the bus
    logic                   s1_valid;
    logic                   s1_write;
    logic [HOST_ADDR_W-1:0] s1_addr;
    logic [HOST_DATA_W-1:0] s1_wdata;
    logic                   s1_is_vreg;
    logic                   s1_is_reg;
    logic                   s1_is_state;
    logic                   s1_is_mem;

    // Stage 2, response
    logic                   s2_mem_read;
    logic [HOST_DATA_W-1:0] s2_data;

    logic [MEM_ADDR_W-1:0]  mem_last_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= chipselect;
        end
    end

    always_ff @(posedge clk) begin
        if (chipselect) begin
            s1_write <= write;
            s1_addr  <= address;
            s1_wdata <= writedata;
        end
    end

    // Memory access word: bit 20 write enable, 19..8 address, 7..0 byte
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_last_addr <= '0;
        end else if (chipselect && write && address == HOST_MEM) begin
            mem_last_addr <= writedata[8 +: MEM_ADDR_W];
        end
    end

    assign s1_is_vreg  = (s1_addr >> VREG_ADDR_W) == (HOST_VREG_BASE >> VREG_ADDR_W);
    assign s1_is_reg   = s1_is_vreg || s1_addr == HOST_I || s1_addr == HOST_PC;
    assign s1_is_state = s1_addr == HOST_STATE;
    assign s1_is_mem   = s1_addr == HOST_MEM;

    assign host_reg_we    = s1_valid & s1_write & s1_is_reg;
    assign host_reg_addr  = s1_addr;
    assign host_reg_wdata = s1_wdata;

    // Granted in the same cycle since the host has priority
    assign mem_req   = s1_valid & s1_is_mem;
    assign mem_we    = mem_req & s1_write & s1_wdata[20];
    assign mem_addr  = mem_last_addr;
    assign mem_wdata = s1_wdata[BYTE_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            run_state <= PAUSED;
        end else if (s1_valid && s1_write && s1_is_state) begin
            case (s1_wdata[1:0])
                2'd0:    run_state <= RUNNING;
                2'd1:    run_state <= STEP;
                default: run_state <= PAUSED;
            endcase
        end else if (step_done) begin
            run_state <= PAUSED;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_valid  <= 1'b0;
            s2_mem_read <= 1'b0;
        end else begin
            data_valid  <= s1_valid;
            s2_mem_read <= mem_req & mem_gnt;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_is_reg) begin
            s2_data <= reg_rdata;
        end else if (s1_is_state) begin
            s2_data <= HOST_DATA_W'(run_state);
        end else begin
            s2_data <= HOST_BAD_READ_VALUE;
        end
    end

    // Memory bytes arrive in stage 2 straight from the RAM
    assign data_out = s2_mem_read
                    ? {{(HOST_DATA_W - MEM_ADDR_W - BYTE_W){1'b0}}, mem_last_addr, mem_rdata}
                    : s2_data;

endmodule

// ==== chip8_mem_arbiter.sv ====
// Fixed-priority arbiter for the single memory port
// Host port first, core second
module chip8_mem_arbiter (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             host_req,
    input  logic                             host_we,
    input  logic [chip8_pkg::MEM_ADDR_W-1:0] host_addr,
    input  logic [chip8_pkg::BYTE_W-1:0]     host_wdata,
    output logic                             host_gnt,
    input  logic                             core_req,
    input  logic                             core_we,
    input  logic [chip8_pkg::MEM_ADDR_W-1:0] core_addr,
    input  logic [chip8_pkg::BYTE_W-1:0]     core_wdata,
    output logic                             core_gnt,
    output logic [chip8_pkg::MEM_ADDR_W-1:0] mem_addr,
    output logic                             mem_we,
    output logic [chip8_pkg::BYTE_W-1:0]     mem_wdata
);

    // Set when the core owns the read data returning this cycle
    logic core_owner;

    // Host always wins
    assign host_gnt = host_req;

    // No core grant while its previous read is still on its way back
    assign core_gnt = core_req & ~host_req & ~core_owner;

    assign mem_addr  = host_req ? host_addr  : core_addr;
    assign mem_wdata = host_req ? host_wdata : core_wdata;
    assign mem_we    = host_req ? host_we    : (core_gnt & core_we);

    always_ff @(posedge clk) begin
        if (reset) begin
            core_owner <= 1'b0;
        end else begin
            core_owner <= core_gnt;
        end
    end

endmodule

// ==== chip8_memory.sv ====
// Byte-wide program memory, one synchronous read/write port
module chip8_memory (
    input  logic                             clk,
    input  logic [chip8_pkg::MEM_ADDR_W-1:0] addr,
    input  logic                             we,
    input  logic [chip8_pkg::BYTE_W-1:0]     wdata,
    output logic [chip8_pkg::BYTE_W-1:0]     rdata
);
    import chip8_pkg::*;

    logic [BYTE_W-1:0] mem [MEM_DEPTH];

    // Write-first, a write shows its own data on the read port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata     <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== chip8_pkg.sv ====
// Shared widths, host register map and reset values
// Run-state, opcode and core phase enums
package chip8_pkg;

    // Program memory
    localparam int MEM_ADDR_W = 12;
    localparam int MEM_DEPTH  = 4096;
    localparam int BYTE_W     = 8;

    // V register file
    localparam int NUM_VREGS   = 16;
    localparam int VREG_ADDR_W = 4;

    // Host bus
    localparam int HOST_ADDR_W = 18;
    localparam int HOST_DATA_W = 32;

    localparam logic [MEM_ADDR_W-1:0] RESET_PC = 12'h200;
    localparam int INSTR_W = 16;

    // Host register addresses, V registers sit at 0x00 to 0x0F
    localparam logic [HOST_ADDR_W-1:0] HOST_VREG_BASE = 18'h00;
    localparam logic [HOST_ADDR_W-1:0] HOST_I         = 18'h10;
    localparam logic [HOST_ADDR_W-1:0] HOST_PC        = 18'h14;
    localparam logic [HOST_ADDR_W-1:0] HOST_STATE     = 18'h16;
    localparam logic [HOST_ADDR_W-1:0] HOST_MEM       = 18'h19;

    // Returned for reads of unmapped addresses
    localparam logic [HOST_DATA_W-1:0] HOST_BAD_READ_VALUE = 32'd101;

    typedef enum logic [1:0] {
        RUNNING = 2'd0,
        STEP    = 2'd1,
        PAUSED  = 2'd2
    } run_state_t;

    // Top nibble of an instruction
    typedef enum logic [3:0] {
        OP_JUMP    = 4'h1,
        OP_SKIP_EQ = 4'h3,
        OP_LOAD    = 4'h6,
        OP_ADD     = 4'h7,
        OP_SET_I   = 4'hA
    } opcode_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_HI,
        FETCH_LO,
        EXECUTE
    } core_phase_t;

endpackage
